/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // ==========================================================
    // Instruction word
    // ==========================================================
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        system = 7'b1110011
    } opcode_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u;
    } instr_u;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_pass_b} alu_op_e;

    typedef enum logic [2:0] {br_none, br_jal, br_jalr, br_eq, br_ne} branch_e;

    typedef struct packed {
        word_t     alu_a;
        word_t     alu_b;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      rd_write;
        branch_e   branch;
        word_t     branch_imm;
        word_t     rs1_value;  // Branch compare and jalr base.
        word_t     rs2_value;  // Branch compare and store data.
        logic      mem_read;
        logic      mem_write;
        logic      illegal;
        logic      halt;
    } decoded_t;

    // ==========================================================
    // Wishbone classic
    // ==========================================================
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat_w;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* source/instr_sequencer.sv */
`default_nettype none
`timescale 1ns/10ps

module instr_sequencer #(
    parameter core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset,
    output core_pkg::wb_req_t  fetch_req,
    input  core_pkg::wb_rsp_t  fetch_rsp,
    output core_pkg::instr_u   instr,
    output core_pkg::word_t    pc,
    input  core_pkg::decoded_t decoded,
    input  core_pkg::word_t    next_pc,
    input  logic               mem_done,
    output logic               start_mem,
    output logic               rd_write_en,
    output logic               halt
);
    import core_pkg::*;

    typedef enum logic [1:0] {st_fetch, st_execute, st_memory, st_halt} state_e;

    state_e state;
    logic   fetch_cyc;
    logic   is_mem;
    logic   stop;

    assign is_mem = decoded.mem_read | decoded.mem_write;
    assign stop   = decoded.halt | decoded.illegal;  // Unknown opcodes stop the core too.

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_fetch;
            fetch_cyc <= 1'b0;
            pc        <= reset_pc;
        end else begin
            case (state)
                st_fetch: begin
                    if (!fetch_cyc) begin
                        fetch_cyc <= 1'b1;
                    end else if (fetch_rsp.ack) begin
                        fetch_cyc <= 1'b0;
                        state     <= st_execute;
                    end
                end
                st_execute: begin
                    if (stop) begin
                        state <= st_halt;
                    end else if (is_mem) begin
                        state <= st_memory;
                    end else begin
                        pc        <= next_pc;
                        fetch_cyc <= 1'b1;  // Next fetch goes out right away.
                        state     <= st_fetch;
                    end
                end
                st_memory: begin
                    if (mem_done) begin
                        pc        <= pc + 32'd4;
                        fetch_cyc <= 1'b1;
                        state     <= st_fetch;
                    end
                end
                default: state <= st_halt;  // Held until reset.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && fetch_cyc && fetch_rsp.ack) begin
            instr <= fetch_rsp.dat_r;
        end
    end

    assign fetch_req = '{cyc: fetch_cyc, stb: fetch_cyc, we: 1'b0, adr: pc,
                         dat_w: '0, sel: 4'hf};

    assign start_mem   = (state == st_execute) && is_mem && !stop;
    assign rd_write_en = ((state == st_execute) && decoded.rd_write && !decoded.mem_read) ||
                         ((state == st_memory) && mem_done && decoded.mem_read);
    assign halt        = (state == st_halt);

endmodule

`default_nettype wire

/* source/decode_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module decode_unit (
    input  core_pkg::instr_u    instr,
    input  core_pkg::word_t     pc,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output core_pkg::decoded_t  decoded
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_addi;
    logic       is_add;
    logic       is_sub;
    logic       is_lui;
    logic       is_auipc;
    logic       is_jal;
    logic       is_jalr;
    logic       is_beq;
    logic       is_bne;
    logic       is_lw;
    logic       is_sw;
    logic       is_ebreak;
    logic       writes_rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;
    logic       use_pc;
    logic       use_imm;
    logic       use_four;
    branch_e    br_kind;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;

    // ==========================================================
    // Instruction match
    // ==========================================================
    assign is_addi   = (opcode == op_imm) && (funct3 == 3'b000);
    assign is_add    = (opcode == op) && (funct3 == 3'b000) && (instr.r.funct7 == 7'b0000000);
    assign is_sub    = (opcode == op) && (funct3 == 3'b000) && (instr.r.funct7 == 7'b0100000);
    assign is_lui    = (opcode == lui);
    assign is_auipc  = (opcode == auipc);
    assign is_jal    = (opcode == jal);
    assign is_jalr   = (opcode == jalr) && (funct3 == 3'b000);
    assign is_beq    = (opcode == branch) && (funct3 == 3'b000);
    assign is_bne    = (opcode == branch) && (funct3 == 3'b001);
    assign is_lw     = (opcode == load) && (funct3 == 3'b010);
    assign is_sw     = (opcode == store) && (funct3 == 3'b010);
    assign is_ebreak = (instr == 32'h0010_0073);

    assign writes_rd = is_addi | is_add | is_sub | is_lui | is_auipc | is_jal | is_jalr | is_lw;

    // ==========================================================
    // Immediates, one per format
    // ==========================================================
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                    instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.u.imm, 12'b0};
    assign imm_j = {{12{instr.u.imm[19]}}, instr.u.imm[7:0], instr.u.imm[8],
                    instr.u.imm[18:9], 1'b0};

    assign imm = ({32{is_addi | is_jalr | is_lw}} & imm_i) |
                 ({32{is_sw}}                     & imm_s) |
                 ({32{is_beq | is_bne}}           & imm_b) |
                 ({32{is_lui | is_auipc}}         & imm_u) |
                 ({32{is_jal}}                    & imm_j);

    // Operand selection.
    assign use_pc   = is_auipc | is_jal | is_jalr | is_beq | is_bne;
    assign use_imm  = is_addi | is_lui | is_auipc | is_lw | is_sw | is_beq | is_bne;
    assign use_four = is_jal | is_jalr;  // Link value pc plus 4.

    assign br_kind = is_jal  ? br_jal  :
                     is_jalr ? br_jalr :
                     is_beq  ? br_eq   :
                     is_bne  ? br_ne   : br_none;

    assign rs1_addr = (is_addi | is_add | is_sub | is_jalr | is_beq | is_bne | is_lw | is_sw) ?
                      instr.r.rs1 : '0;
    assign rs2_addr = (is_add | is_sub | is_beq | is_bne | is_sw) ? instr.r.rs2 : '0;

    always_comb begin
        decoded.alu_a      = use_pc ? pc : rs1_data;
        decoded.alu_b      = use_imm ? imm : use_four ? 32'd4 : rs2_data;
        decoded.alu_op     = is_sub ? alu_sub : is_lui ? alu_pass_b : alu_add;
        decoded.rd         = writes_rd ? instr.r.rd : '0;
        decoded.rd_write   = writes_rd;
        decoded.branch     = br_kind;
        decoded.branch_imm = (br_kind != br_none) ? imm : '0;
        decoded.rs1_value  = rs1_data;
        decoded.rs2_value  = rs2_data;
        decoded.mem_read   = is_lw;
        decoded.mem_write  = is_sw;
        decoded.illegal    = !(writes_rd | is_beq | is_bne | is_sw | is_ebreak);
        decoded.halt       = is_ebreak;
    end

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module execute_unit (
    input  core_pkg::decoded_t decoded,
    input  core_pkg::word_t    pc,
    output core_pkg::word_t    alu_result,
    output core_pkg::word_t    next_pc
);
    import core_pkg::*;

    word_t sum;
    word_t diff;
    word_t jalr_target;
    logic  equal;
    logic  taken;

    // ==========================================================
    // ALU
    // ==========================================================
    assign sum  = decoded.alu_a + decoded.alu_b;
    assign diff = decoded.alu_a - decoded.alu_b;

    always_comb begin
        case (decoded.alu_op)
            alu_sub:    alu_result = diff;
            alu_pass_b: alu_result = decoded.alu_b;  // lui.
            default:    alu_result = sum;
        endcase
    end

    // ==========================================================
    // Branch and next pc
    // ==========================================================
    assign equal       = (decoded.rs1_value == decoded.rs2_value);
    assign jalr_target = decoded.rs1_value + decoded.branch_imm;

    always_comb begin
        case (decoded.branch)
            br_jal:  taken = 1'b1;
            br_eq:   taken = equal;
            br_ne:   taken = !equal;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (decoded.branch == br_jalr) begin
            next_pc = {jalr_target[31:1], 1'b0};
        end else if (taken) begin
            next_pc = pc + decoded.branch_imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::word_t     rd_data,
    input  logic                write_en
);
    import core_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 always reads as zero.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* source/load_store_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module load_store_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  core_pkg::decoded_t decoded,
    input  core_pkg::word_t    address,
    output core_pkg::wb_req_t  mem_req,
    input  core_pkg::wb_rsp_t  mem_rsp,
    output core_pkg::word_t    load_data,
    output logic               done
);
    import core_pkg::*;

    logic  busy;
    logic  we_r;
    word_t adr_r;
    word_t dat_w_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            we_r <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            we_r <= decoded.mem_write;
        end else if (busy && mem_rsp.ack) begin
            busy <= 1'b0;  // cyc drops the cycle after ack.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_r   <= address;
            dat_w_r <= decoded.rs2_value;
        end
    end

    assign mem_req = '{cyc: busy, stb: busy, we: we_r, adr: adr_r,
                       dat_w: dat_w_r, sel: 4'hf};

    assign load_data = mem_rsp.dat_r;
    assign done      = busy & mem_rsp.ack;

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/10ps

module bus_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::wb_req_t fetch_req,
    input  core_pkg::wb_req_t lsu_req,
    output core_pkg::wb_rsp_t fetch_rsp,
    output core_pkg::wb_rsp_t lsu_rsp,
    output core_pkg::wb_req_t bus_req,
    input  core_pkg::wb_rsp_t bus_rsp
);
    logic busy;
    logic owner_lsu;
    logic pick_lsu;

    // Load/store wins when the bus is idle.
    assign pick_lsu = busy ? owner_lsu : lsu_req.cyc;

    assign bus_req = pick_lsu ? lsu_req : fetch_req;

    always_comb begin
        fetch_rsp     = bus_rsp;
        lsu_rsp       = bus_rsp;
        fetch_rsp.ack = bus_rsp.ack & !pick_lsu;
        lsu_rsp.ack   = bus_rsp.ack & pick_lsu;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            owner_lsu <= 1'b0;
        end else if (!busy) begin
            if (bus_req.cyc && !bus_rsp.ack) begin
                busy      <= 1'b1;
                owner_lsu <= pick_lsu;
            end
        end else if (bus_rsp.ack) begin
            busy <= 1'b0;  // Released at the end of the cycle.
        end
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_core #(
    parameter core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset,
    output core_pkg::wb_req_t bus_req,
    input  core_pkg::wb_rsp_t bus_rsp,
    output logic              halt
);
    import core_pkg::*;

    wb_req_t   fetch_req;
    wb_req_t   lsu_req;
    wb_rsp_t   fetch_rsp;
    wb_rsp_t   lsu_rsp;
    instr_u    instr;
    word_t     pc;
    word_t     next_pc;
    word_t     alu_result;
    word_t     load_data;
    word_t     rd_data;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    decoded_t  decoded;
    logic      mem_done;
    logic      start_mem;
    logic      rd_write_en;

    assign rd_data = decoded.mem_read ? load_data : alu_result;

    instr_sequencer #(.reset_pc(reset_pc)) u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .instr       (instr),
        .pc          (pc),
        .decoded     (decoded),
        .next_pc     (next_pc),
        .mem_done    (mem_done),
        .start_mem   (start_mem),
        .rd_write_en (rd_write_en),
        .halt        (halt)
    );

    decode_unit u_decode (
        .instr    (instr),
        .pc       (pc),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .decoded  (decoded)
    );

    execute_unit u_execute (
        .decoded    (decoded),
        .pc         (pc),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_addr  (decoded.rd),
        .rd_data  (rd_data),
        .write_en (rd_write_en)
    );

    load_store_unit u_lsu (
        .clk       (clk),
        .reset     (reset),
        .start     (start_mem),
        .decoded   (decoded),
        .address   (alu_result),
        .mem_req   (lsu_req),
        .mem_rsp   (lsu_rsp),
        .load_data (load_data),
        .done      (mem_done)
    );

    bus_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .lsu_req   (lsu_req),
        .fetch_rsp (fetch_rsp),
        .lsu_rsp   (lsu_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

endmodule

`default_nettype wire

/* tb/wb_memory.sv */
`default_nettype none
`timescale 1ns/10ps

module wb_memory (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::wb_req_t bus_req,
    output core_pkg::wb_rsp_t bus_rsp
);
    import core_pkg::*;

    word_t       mem [0:255];
    integer      seed;
    logic [31:0] draw;
    logic [1:0]  wait_left;
    logic        active;
    logic        ack;
    word_t       dat_r;
    logic [7:0]  index;

    initial begin
        seed = 49;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'ha5a5_0000 ^ (i * 4);  // Fill follows the byte address.
        end
    end

    task automatic load_word(input int word_index, input word_t value);
        mem[word_index] = value;
    endtask

    assign index   = bus_req.adr[9:2];
    assign bus_rsp = '{ack: ack, dat_r: dat_r};

    always @(posedge clk) begin
        if (reset) begin
            ack       <= 1'b0;
            active    <= 1'b0;
            wait_left <= 2'd0;
        end else if (ack) begin
            ack <= 1'b0;  // One-cycle ack.
        end else if (bus_req.cyc && bus_req.stb) begin
            if (!active) begin
                draw = $random(seed);
                active    <= 1'b1;
                wait_left <= draw[1:0];  // 0 to 3 wait states.
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                active <= 1'b0;
                ack    <= 1'b1;
                if (bus_req.we) begin
                    mem[index] = bus_req.dat_w;
                end else begin
                    dat_r <= mem[index];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/rv_core_props.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_core_props (
    input logic              clk,
    input logic              reset,
    input core_pkg::wb_req_t bus_req,
    input core_pkg::wb_rsp_t bus_rsp,
    input logic              halt
);

    // ==========================================================
    // Bus protocol
    // ==========================================================
    request_stable: assert property (@(posedge clk) disable iff (reset)
        (bus_req.stb && !bus_rsp.ack) |=> $stable(bus_req))
        else $error("bus request changed while waiting for ack");

    no_cycle_when_idle: assert property (@(posedge clk)
        ((reset && $past(reset)) || halt) |-> !bus_req.cyc)
        else $error("bus cycle started during reset or after halt");

    // Halt is left only through reset.
    halt_held: assert property (@(posedge clk)
        (halt && !reset) |=> halt)
        else $error("halt fell without reset");

endmodule

bind rv_core rv_core_props u_props (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .halt    (halt)
);

`default_nettype wire

/* tb/tb_rv_core.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_rv_core;
    import core_pkg::*;

    localparam word_t      reset_pc      = 32'h0000_0000;
    localparam int         fetch_timeout = 20;
    localparam int         halt_timeout  = 4000;
    localparam logic [6:0] opc_imm       = 7'h13;
    localparam logic [6:0] opc_reg       = 7'h33;
    localparam logic [6:0] opc_lui       = 7'h37;
    localparam logic [6:0] opc_auipc     = 7'h17;
    localparam logic [6:0] opc_jal       = 7'h6f;
    localparam logic [6:0] opc_jalr      = 7'h67;
    localparam logic [6:0] opc_branch    = 7'h63;
    localparam logic [6:0] opc_load      = 7'h03;
    localparam logic [6:0] opc_store     = 7'h23;

    logic    clk;
    logic    reset;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    logic    halt;
    word_t   program_mem [0:63];
    word_t   exp_addr [$];
    word_t   exp_data [$];
    logic    exp_halt;
    int      mismatch_count;
    int      failure_count;
    int      store_count;

    rv_core #(.reset_pc(reset_pc)) UUT (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .halt    (halt)
    );

    wb_memory u_memory (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    always #50 clk = ~clk;

    // ==========================================================
    // Instruction encoders
    // ==========================================================
    function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, opc_reg};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            program_mem[i] = 32'h0000_0013;
        end
        program_mem[0]  = i_type(12'h100, 5'd0, 3'b000, 5'd1, opc_imm);  // Data base.
        program_mem[1]  = i_type(12'd25, 5'd0, 3'b000, 5'd2, opc_imm);
        program_mem[2]  = i_type(12'hff9, 5'd0, 3'b000, 5'd3, opc_imm);  // Minus 7.
        program_mem[3]  = r_type(7'h00, 5'd3, 5'd2, 5'd4);
        program_mem[4]  = s_type(12'd0, 5'd4, 5'd1);
        program_mem[5]  = r_type(7'h20, 5'd3, 5'd2, 5'd5);
        program_mem[6]  = s_type(12'd4, 5'd5, 5'd1);
        program_mem[7]  = u_type(20'h12345, 5'd6, opc_lui);
        program_mem[8]  = i_type(12'h678, 5'd6, 3'b000, 5'd6, opc_imm);
        program_mem[9]  = s_type(12'd8, 5'd6, 5'd1);
        program_mem[10] = u_type(20'h00001, 5'd7, opc_auipc);
        program_mem[11] = s_type(12'd12, 5'd7, 5'd1);
        program_mem[12] = j_type(21'd8, 5'd8);
        program_mem[13] = s_type(12'd16, 5'd0, 5'd1);  // Skipped by jal.
        program_mem[14] = s_type(12'd16, 5'd8, 5'd1);
        program_mem[15] = b_type(13'd8, 5'd2, 5'd2, 3'b000);
        program_mem[16] = s_type(12'd20, 5'd2, 5'd1);  // Skipped by beq.
        program_mem[17] = b_type(13'd8, 5'd2, 5'd2, 3'b001);
        program_mem[18] = s_type(12'd20, 5'd3, 5'd1);
        program_mem[19] = b_type(13'd8, 5'd3, 5'd2, 3'b001);
        program_mem[20] = s_type(12'd24, 5'd0, 5'd1);  // Skipped by bne.
        program_mem[21] = b_type(13'd8, 5'd3, 5'd2, 3'b000);
        program_mem[22] = i_type(12'd108, 5'd0, 3'b000, 5'd9, opc_imm);
        program_mem[23] = i_type(12'd1, 5'd9, 3'b000, 5'd10, opc_jalr);  // Odd target.
        program_mem[24] = s_type(12'd24, 5'd0, 5'd1);
        program_mem[25] = s_type(12'd28, 5'd0, 5'd1);
        program_mem[26] = s_type(12'd32, 5'd0, 5'd1);
        program_mem[27] = s_type(12'd24, 5'd10, 5'd1);
        program_mem[28] = i_type(12'd24, 5'd1, 3'b010, 5'd11, opc_load);
        program_mem[29] = s_type(12'd28, 5'd11, 5'd1);
        program_mem[30] = i_type(12'd4, 5'd1, 3'b010, 5'd12, opc_load);
        program_mem[31] = i_type(12'd1, 5'd12, 3'b000, 5'd12, opc_imm);
        program_mem[32] = s_type(12'd32, 5'd12, 5'd1);
        program_mem[33] = 32'h0010_0073;  // ebreak.
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================
    function automatic void run_reference();
        word_t      regs [0:31];
        word_t      data [0:255];
        word_t      pc;
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      result;
        word_t      next;
        logic       write_rd;
        logic       stop;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            data[i] = (i < 64) ? program_mem[i] : '0;
        end
        exp_halt = 1'b0;
        stop     = 1'b0;
        pc       = reset_pc;
        for (int step = 0; step < 1000 && !stop; step++) begin
            w        = data[pc[9:2]];
            a        = regs[w[19:15]];
            b        = regs[w[24:20]];
            write_rd = 1'b1;
            result   = '0;
            next     = pc + 32'd4;
            case (w[6:0])
                opc_imm:   result = a + {{20{w[31]}}, w[31:20]};
                opc_reg:   result = w[30] ? a - b : a + b;
                opc_lui:   result = {w[31:12], 12'b0};
                opc_auipc: result = pc + {w[31:12], 12'b0};
                opc_jal: begin
                    result = pc + 32'd4;
                    next   = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                opc_jalr: begin
                    result = pc + 32'd4;
                    next   = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
                end
                opc_branch: begin
                    write_rd = 1'b0;
                    if ((a == b) ^ w[12]) begin
                        next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                opc_load: begin
                    addr   = a + {{20{w[31]}}, w[31:20]};
                    result = data[addr[9:2]];
                end
                opc_store: begin
                    write_rd = 1'b0;
                    addr     = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    data[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                default: begin
                    write_rd = 1'b0;  // ebreak and unknown words stop the core.
                    stop     = 1'b1;
                    exp_halt = 1'b1;
                end
            endcase
            if (write_rd && w[11:7] != 5'd0) begin
                regs[w[11:7]] = result;
            end
            pc = next;
        end
    endfunction

    task automatic compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic compare_sel(input string name, input logic [3:0] actual,
                               input logic [3:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    // Store trace checked against the model at the falling edge.
    always @(negedge clk) begin
        if (!reset && bus_req.cyc && bus_req.stb && bus_req.we && bus_rsp.ack) begin
            if (store_count >= exp_addr.size()) begin
                $display("Unexpected store at %0t to address %h", $time, bus_req.adr);
                failure_count++;
            end else begin
                compare_word("bus_req.adr", bus_req.adr, exp_addr[store_count]);
                compare_word("bus_req.dat_w", bus_req.dat_w, exp_data[store_count]);
                compare_sel("bus_req.sel", bus_req.sel, 4'hf);
            end
            store_count++;
        end
    end

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int cycles;
        clk            = 1'b0;
        reset          = 1'b1;
        mismatch_count = 0;
        failure_count  = 0;
        store_count    = 0;
        load_program();
        run_reference();
        #1;
        for (int i = 0; i < 64; i++) begin
            u_memory.load_word(i, program_mem[i]);
        end
        repeat (4) @(negedge clk);
        check_level("bus_req.cyc", bus_req.cyc, 1'b0);
        check_level("bus_req.stb", bus_req.stb, 1'b0);
        check_level("halt", halt, 1'b0);
        @(negedge clk);
        reset = 1'b0;  // Five rising edges in reset.

        cycles = 0;
        while (!bus_req.cyc && cycles < fetch_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!bus_req.cyc) begin
            $display("The first instruction fetch never started");
            failure_count++;
        end else begin
            compare_word("bus_req.adr", bus_req.adr, reset_pc);
            check_level("bus_req.we", bus_req.we, 1'b0);
        end

        cycles = 0;
        while (!halt && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("The core did not halt within %0d cycles", halt_timeout);
            failure_count++;
        end else begin
            for (int n = 0; n < 20; n++) begin
                @(negedge clk);
                check_level("halt", halt, exp_halt);
                check_level("bus_req.cyc", bus_req.cyc, 1'b0);
            end
            if (store_count != exp_addr.size()) begin
                $display("Saw %0d stores on the bus, the model made %0d",
                         store_count, exp_addr.size());
                failure_count++;
            end
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/core_pkg.sv
source/instr_sequencer.sv
source/decode_unit.sv
source/execute_unit.sv
source/register_file.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/rv_core.sv
tb/wb_memory.sv
tb/rv_core_props.sv
tb/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f project.f \
        -o tb_rv_core > build.log 2>&1 \
    && ./obj_dir/tb_rv_core > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

! grep -q "TB FAILED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
